/* ifd_config.svh */
// Widths, depths, window base addresses and thread count for fetch/decode
`ifndef IFD_CONFIG_SVH
`define IFD_CONFIG_SVH

// ------------------------------------------------------------------------
// Write bus and instruction word

`define IFD_WORD_WIDTH      32
`define IFD_ADDR_WIDTH      12

// Instruction format, MSB first: opcode, D, A, B
`define IFD_OPCODE_WIDTH    4
`define IFD_D_WIDTH         10
`define IFD_A_WIDTH         9
`define IFD_B_WIDTH         9

// ------------------------------------------------------------------------
// Memories

`define IFD_IM_ADDR_WIDTH   10
`define IFD_IM_DEPTH        (1 << `IFD_IM_ADDR_WIDTH)

`define IFD_THREAD_COUNT    4
`define IFD_THREAD_WIDTH    2

// One ALU control word per thread and opcode
`define IFD_CTRL_WIDTH      20
`define IFD_OD_ADDR_WIDTH   (`IFD_THREAD_WIDTH + `IFD_OPCODE_WIDTH)
`define IFD_OD_DEPTH        (`IFD_THREAD_COUNT << `IFD_OPCODE_WIDTH)

// ------------------------------------------------------------------------
// Write address map

`define IFD_IM_BASE         12'h400
`define IFD_OD_BASE         12'h800

// Added to D to reach the B-side data memory
`define IFD_DB_BASE         10'h200

// AXI4-Lite response code
`define IFD_AXI_RESP_OKAY   2'b00

`endif

/* ifd_pkg.sv */
// Vector typedefs, write request, memory write, decoded output and host FSM states
`include "ifd_config.svh"

package ifd_pkg;

    // --------------------------------------------------------------------
    // Plain vectors

    typedef logic [`IFD_ADDR_WIDTH-1:0]    addr_t;
    typedef logic [`IFD_WORD_WIDTH-1:0]    word_t;
    typedef logic [`IFD_IM_ADDR_WIDTH-1:0] im_addr_t;
    typedef logic [`IFD_OPCODE_WIDTH-1:0]  opcode_t;
    typedef logic [`IFD_D_WIDTH-1:0]       d_operand_t;
    typedef logic [`IFD_A_WIDTH-1:0]       a_operand_t;
    typedef logic [`IFD_B_WIDTH-1:0]       b_operand_t;
    typedef logic [`IFD_THREAD_WIDTH-1:0]  thread_t;
    typedef logic [`IFD_CTRL_WIDTH-1:0]    alu_ctrl_t;

    // --------------------------------------------------------------------
    // Bus structs

    // From a writer to the arbiter, and from the arbiter to the decoder
    typedef struct packed {
        logic  valid;
        addr_t addr;
        word_t data;
    } write_req_t;

    // Index is 0-based inside whichever window was hit
    typedef struct packed {
        logic  im_wren;
        logic  od_wren;
        addr_t index;
        word_t data;
    } mem_write_t;

    typedef struct packed {
        alu_ctrl_t  alu_control;
        d_operand_t da;
        d_operand_t db;
        a_operand_t a;
        b_operand_t b;
    } decoded_t;

    // --------------------------------------------------------------------
    // Host write port FSM

    typedef enum logic [1:0] {
        idle,
        wait_grant,
        resp
    } host_state_t;

endpackage

/* host_write_port.sv */
// AXI4-Lite write-only slave producing write requests for the arbiter
`timescale 1ns/1ps
`default_nettype none
`include "ifd_config.svh"

module host_write_port (
    input  logic               clock,
    input  logic               rst,

    input  logic               aw_valid,
    output logic               aw_ready,
    input  ifd_pkg::addr_t     aw_addr,

    input  logic               w_valid,
    output logic               w_ready,
    input  ifd_pkg::word_t     w_data,

    output logic               b_valid,
    input  logic               b_ready,
    output logic [1:0]         b_resp,

    output ifd_pkg::write_req_t host_req,
    input  logic               host_grant
);

    import ifd_pkg::*;

    host_state_t state;
    addr_t       req_addr;
    word_t       req_data;
    logic        accept;

    // ------------------------------------------------------------------------
    // AW and W are taken together, only while idle

    assign accept   = (state == idle) && aw_valid && w_valid;
    assign aw_ready = accept;
    assign w_ready  = accept;

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (accept) begin
                        state <= wait_grant;
                    end
                end
                wait_grant: begin
                    if (host_grant) begin
                        state <= resp;
                    end
                end
                resp: begin
                    if (b_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    // Address and data held until the arbiter takes them
    always_ff @(posedge clock) begin
        if (accept) begin
            req_addr <= aw_addr;
            req_data <= w_data;
        end
    end

    // ------------------------------------------------------------------------
    // Request and response

    always_comb begin
        host_req.valid = (state == wait_grant);
        host_req.addr  = req_addr;
        host_req.data  = req_data;
    end

    // Writes outside both windows are answered OKAY as well
    assign b_valid = (state == resp);
    assign b_resp  = `IFD_AXI_RESP_OKAY;

    // A pending request must not change while core writes hold it off
    a_host_req_stable: assert property (
        @(posedge clock) disable iff (rst)
        host_req.valid && !host_grant |=> $stable(host_req)
    );

endmodule

`default_nettype wire

/* write_arbiter.sv */
// Fixed-priority write arbiter, core path first, host otherwise
`timescale 1ns/1ps
`default_nettype none

module write_arbiter (
    input  ifd_pkg::write_req_t core_req,
    input  logic                ior_previous,
    input  logic                cancel_previous,

    input  ifd_pkg::write_req_t host_req,
    output logic                host_grant,

    output ifd_pkg::write_req_t granted_req
);

    logic core_ok;

    // ------------------------------------------------------------------------
    // Core write counts only for an instruction neither annulled nor cancelled

    assign core_ok = core_req.valid && ior_previous && !cancel_previous;

    // Core has no back-pressure, so the host takes any free cycle
    assign host_grant = host_req.valid && !core_ok;

    always_comb begin
        granted_req       = host_req;
        granted_req.valid = host_grant;
        if (core_ok) begin
            granted_req = core_req;
        end
    end

endmodule

`default_nettype wire

/* write_space_decoder.sv */
// Address window decode into instruction or opcode decoder memory writes
`timescale 1ns/1ps
`default_nettype none
`include "ifd_config.svh"

module write_space_decoder (
    input  ifd_pkg::write_req_t granted_req,
    output ifd_pkg::mem_write_t mem_write
);

    import ifd_pkg::*;

    // ------------------------------------------------------------------------
    // Window bounds, upper bound exclusive

    localparam addr_t im_base  = `IFD_IM_BASE;
    localparam addr_t im_bound = `IFD_IM_BASE + `IFD_IM_DEPTH;
    localparam addr_t od_base  = `IFD_OD_BASE;
    localparam addr_t od_bound = `IFD_OD_BASE + `IFD_OD_DEPTH;

    logic  im_hit;
    logic  od_hit;
    addr_t im_offset;
    addr_t od_offset;

    assign im_hit = (granted_req.addr >= im_base) && (granted_req.addr < im_bound);
    assign od_hit = (granted_req.addr >= od_base) && (granted_req.addr < od_bound);

    // Translate into 0-based indexes
    assign im_offset = granted_req.addr - im_base;
    assign od_offset = granted_req.addr - od_base;

    // ------------------------------------------------------------------------
    // Enables, misses fall through silently

    always_comb begin
        mem_write.im_wren = granted_req.valid && im_hit;
        mem_write.od_wren = granted_req.valid && od_hit;
        mem_write.data    = granted_req.data;
        if (im_hit) begin
            mem_write.index = im_offset;
        end else begin
            mem_write.index = od_offset;
        end
    end

endmodule

`default_nettype wire

/* instruction_fetch_decode.sv */
// Instruction memory, per-thread opcode decoder memory and two-stage fetch/decode
`timescale 1ns/1ps
`default_nettype none
`include "ifd_config.svh"

module instruction_fetch_decode (
    input  logic                clock,
    input  logic                rst,

    input  ifd_pkg::mem_write_t mem_write,

    input  ifd_pkg::im_addr_t   im_read_addr,
    output logic                fetch_valid,
    output ifd_pkg::decoded_t   fetch_out
);

    import ifd_pkg::*;

    // ------------------------------------------------------------------------
    // Memories

    word_t     imem [0:`IFD_IM_DEPTH-1];
    alu_ctrl_t odmem [0:`IFD_OD_DEPTH-1];

    logic [`IFD_OD_ADDR_WIDTH-1:0] od_read_index;

    // Reads in the same cycle see the old contents
    always_ff @(posedge clock) begin
        if (mem_write.im_wren) begin
            imem[mem_write.index[`IFD_IM_ADDR_WIDTH-1:0]] <= mem_write.data;
        end
        if (mem_write.od_wren) begin
            odmem[mem_write.index[`IFD_OD_ADDR_WIDTH-1:0]] <= mem_write.data[`IFD_CTRL_WIDTH-1:0];
        end
    end

    // ------------------------------------------------------------------------
    // Barrel thread slot, one per cycle

    thread_t slot;

    always_ff @(posedge clock) begin
        if (rst) begin
            slot <= '0;
        end else if (slot == thread_t'(`IFD_THREAD_COUNT - 1)) begin
            slot <= '0;
        end else begin
            slot <= slot + 1'b1;
        end
    end

    // ------------------------------------------------------------------------
    // Stage 1: fetch and split the instruction word

    logic       s1_valid;
    thread_t    s1_thread;
    opcode_t    s1_opcode;
    d_operand_t s1_d;
    a_operand_t s1_a;
    b_operand_t s1_b;

    always_ff @(posedge clock) begin
        if (rst) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= 1'b1;
        end
    end

    // Thread travels with the fetch it belongs to
    always_ff @(posedge clock) begin
        {s1_opcode, s1_d, s1_a, s1_b} <= imem[im_read_addr];
        s1_thread <= slot;
    end

    // ------------------------------------------------------------------------
    // Stage 2: per-thread opcode lookup and operand forming

    assign od_read_index = {s1_thread, s1_opcode};

    always_ff @(posedge clock) begin
        if (rst) begin
            fetch_valid <= 1'b0;
        end else begin
            fetch_valid <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        fetch_out.alu_control <= odmem[od_read_index];
        fetch_out.da          <= s1_d;
        fetch_out.db          <= s1_d + `IFD_DB_BASE;   // wraps inside D width
        fetch_out.a           <= s1_a;
        fetch_out.b           <= s1_b;
    end

    // Window decode upstream must pick at most one memory
    a_single_wren: assert property (
        @(posedge clock) disable iff (rst)
        !(mem_write.im_wren && mem_write.od_wren)
    );

endmodule

`default_nettype wire

/* ifd_mapped_top.sv */
// Top level joining host port, write arbiter, address decoder and fetch/decode
`timescale 1ns/1ps
`default_nettype none

module ifd_mapped_top (
    input  logic                clock,
    input  logic                rst,

    // AXI4-Lite write channels
    input  logic                aw_valid,
    output logic                aw_ready,
    input  ifd_pkg::addr_t      aw_addr,
    input  logic                w_valid,
    output logic                w_ready,
    input  ifd_pkg::word_t      w_data,
    output logic                b_valid,
    input  logic                b_ready,
    output logic [1:0]          b_resp,

    // Core write path
    input  ifd_pkg::write_req_t core_req,
    input  logic                ior_previous,
    input  logic                cancel_previous,

    // Fetch
    input  ifd_pkg::im_addr_t   im_read_addr,
    output logic                fetch_valid,
    output ifd_pkg::decoded_t   fetch_out
);

    import ifd_pkg::*;

    write_req_t host_req;
    logic       host_grant;
    write_req_t granted_req;
    mem_write_t mem_write;

    // ------------------------------------------------------------------------
    // Write side

    host_write_port host_write_port_i (
        .clock      (clock),
        .rst        (rst),
        .aw_valid   (aw_valid),
        .aw_ready   (aw_ready),
        .aw_addr    (aw_addr),
        .w_valid    (w_valid),
        .w_ready    (w_ready),
        .w_data     (w_data),
        .b_valid    (b_valid),
        .b_ready    (b_ready),
        .b_resp     (b_resp),
        .host_req   (host_req),
        .host_grant (host_grant)
    );

    write_arbiter write_arbiter_i (
        .core_req        (core_req),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .host_req        (host_req),
        .host_grant      (host_grant),
        .granted_req     (granted_req)
    );

    write_space_decoder write_space_decoder_i (
        .granted_req (granted_req),
        .mem_write   (mem_write)
    );

    // ------------------------------------------------------------------------
    // Read side

    instruction_fetch_decode instruction_fetch_decode_i (
        .clock        (clock),
        .rst          (rst),
        .mem_write    (mem_write),
        .im_read_addr (im_read_addr),
        .fetch_valid  (fetch_valid),
        .fetch_out    (fetch_out)
    );

endmodule

`default_nettype wire

/* tb_ifd_checker.sv */
// Checker comparing fetch results, B responses and reset state with the testbench model
`timescale 1ns/1ps
`include "ifd_config.svh"

module tb_ifd_checker (
    input  logic              clock,
    input  logic              rst,
    input  logic              aw_valid,
    input  logic              aw_ready,
    input  logic              w_valid,
    input  logic              w_ready,
    input  logic              b_valid,
    input  logic              b_ready,
    input  logic [1:0]        b_resp,
    input  logic              fetch_valid,
    input  ifd_pkg::decoded_t fetch_out,
    input  logic              exp_valid,
    input  ifd_pkg::decoded_t exp_out,
    input  int                test_id,
    input  logic              check_end,
    output int                error_count,
    output int                compare_count
);

    import ifd_pkg::*;

    int       release_edges;
    int       aw_count;
    int       b_count;
    logic     s1_valid;
    decoded_t s1_out;
    int       s1_id;
    logic     s2_valid;
    decoded_t s2_out;
    int       s2_id;

    function automatic string test_name(input int id);
        case (id)
            1:       return "host_loading";
            2:       return "annul_cancel";
            3:       return "out_of_range";
            4:       return "arbitration";
            5:       return "per_thread_decode";
            default: return "reset";
        endcase
    endfunction

    task automatic expect_bit(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("MISMATCH %s %s expected %b actual %b", test_name(test_id), what,
                     expected, actual);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------------------
    // Expected fetch results follow the DUT's two register stages

    always @(posedge clock) begin
        if (rst) begin
            release_edges <= 0;
            s1_valid      <= 1'b0;
            s2_valid      <= 1'b0;
        end else begin
            release_edges <= release_edges + 1;
            s1_valid      <= exp_valid;
            s1_out        <= exp_out;
            s1_id         <= test_id;
            s2_valid      <= s1_valid;
            s2_out        <= s1_out;
            s2_id         <= s1_id;
        end
    end

    // ------------------------------------------------------------------------
    // Inputs only move just after the rising edge, so the falling edge is quiet

    always @(negedge clock) begin
        if (rst || release_edges < 2) begin
            expect_bit("aw_ready", 1'b0, aw_ready);
            expect_bit("w_ready", 1'b0, w_ready);
            expect_bit("b_valid", 1'b0, b_valid);
        end
        // Valid two edges after the first fetch is sampled
        expect_bit("fetch_valid", !rst && release_edges >= 2, fetch_valid);

        if (aw_valid && aw_ready) begin
            aw_count++;
            expect_bit("w handshake with aw", 1'b1, w_valid && w_ready);
        end
        if (b_valid && b_ready) begin
            b_count++;
            if (b_resp !== `IFD_AXI_RESP_OKAY) begin
                $display("MISMATCH %s b_resp expected %b actual %b", test_name(test_id),
                         `IFD_AXI_RESP_OKAY, b_resp);
                error_count++;
            end
        end

        if (s2_valid) begin
            compare_count++;
            if (fetch_out !== s2_out) begin
                $display("MISMATCH %s fetch_out expected %h actual %h", test_name(s2_id),
                         s2_out, fetch_out);
                error_count++;
            end
        end

        // One B response for every accepted AW/W pair
        if (check_end && (b_count != aw_count)) begin
            $display("MISMATCH %s b_responses expected %0d actual %0d", test_name(test_id),
                     aw_count, b_count);
            error_count++;
        end
    end

endmodule

/* tb_ifd.sv */
// Testbench top with clock, reset, random AXI and core stimulus, reference model and watchdog
`timescale 1ns/1ps
`include "ifd_config.svh"

module tb_ifd;

    import ifd_pkg::*;

    // ------------------------------------------------------------------------
    // Test ids, sequence lengths and the watchdog budget

    localparam int t_reset           = 0;
    localparam int t_host_loading    = 1;
    localparam int t_annul_cancel    = 2;
    localparam int t_out_of_range    = 3;
    localparam int t_arbitration     = 4;
    localparam int t_per_thread      = 5;

    localparam int im_base           = `IFD_IM_BASE;
    localparam int od_base           = `IFD_OD_BASE;
    localparam int im_depth          = `IFD_IM_DEPTH;
    localparam int od_depth          = `IFD_OD_DEPTH;
    localparam int op_lsb            = `IFD_WORD_WIDTH - `IFD_OPCODE_WIDTH;
    localparam int d_lsb             = op_lsb - `IFD_D_WIDTH;
    localparam int a_lsb             = d_lsb - `IFD_A_WIDTH;

    localparam int load_writes       = 48;
    localparam int core_phase_writes = 40;
    localparam int range_writes      = 16;
    localparam int burst_len         = 40;
    localparam int burst_host_writes = 8;
    localparam int thread_words      = 16;
    localparam int wait_limit        = burst_len + 20;

    localparam int host_write_total  = od_depth + load_writes + range_writes
                                     + burst_host_writes + `IFD_THREAD_COUNT + thread_words;
    localparam int queue_max         = load_writes + burst_len + burst_host_writes;
    localparam int run_cycles        = host_write_total * 6 + core_phase_writes + burst_len
                                     + 4 * (queue_max + 4) + 2 * (thread_words + 4) + 20;
    localparam int watchdog_ns       = 2 * run_cycles * 10 + 2000;

    logic       clock;
    logic       rst;
    logic       aw_valid;
    logic       aw_ready;
    addr_t      aw_addr;
    logic       w_valid;
    logic       w_ready;
    word_t      w_data;
    logic       b_valid;
    logic       b_ready;
    logic [1:0] b_resp;
    write_req_t core_req;
    logic       ior_previous;
    logic       cancel_previous;
    im_addr_t   im_read_addr;
    logic       fetch_valid;
    decoded_t   fetch_out;

    logic       exp_valid;
    decoded_t   exp_out;
    int         test_id;
    logic       check_end;
    int         checker_errors;
    int         compare_count;
    int         driver_errors;
    int         release_edges;
    integer     seed = 53745;

    // Reference model of both memories and the addresses worth fetching
    word_t      model_imem [0:im_depth-1];
    alu_ctrl_t  model_od [0:od_depth-1];
    im_addr_t   written_q [$];

    ifd_mapped_top ifd_mapped_top_i (
        .clock           (clock),
        .rst             (rst),
        .aw_valid        (aw_valid),
        .aw_ready        (aw_ready),
        .aw_addr         (aw_addr),
        .w_valid         (w_valid),
        .w_ready         (w_ready),
        .w_data          (w_data),
        .b_valid         (b_valid),
        .b_ready         (b_ready),
        .b_resp          (b_resp),
        .core_req        (core_req),
        .ior_previous    (ior_previous),
        .cancel_previous (cancel_previous),
        .im_read_addr    (im_read_addr),
        .fetch_valid     (fetch_valid),
        .fetch_out       (fetch_out)
    );

    tb_ifd_checker tb_ifd_checker_i (
        .clock         (clock),
        .rst           (rst),
        .aw_valid      (aw_valid),
        .aw_ready      (aw_ready),
        .w_valid       (w_valid),
        .w_ready       (w_ready),
        .b_valid       (b_valid),
        .b_ready       (b_ready),
        .b_resp        (b_resp),
        .fetch_valid   (fetch_valid),
        .fetch_out     (fetch_out),
        .exp_valid     (exp_valid),
        .exp_out       (exp_out),
        .test_id       (test_id),
        .check_end     (check_end),
        .error_count   (checker_errors),
        .compare_count (compare_count)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // Thread slot of a fetch driven now and sampled at the next edge
    always @(posedge clock) begin
        if (rst) begin
            release_edges <= 0;
        end else begin
            release_edges <= release_edges + 1;
        end
    end

    // ------------------------------------------------------------------------
    // Model

    function automatic int rand_below(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    function automatic word_t rand_word();
        return word_t'($random(seed));
    endfunction

    // Window rules, anything outside both windows is dropped
    function automatic void model_write(input addr_t addr, input word_t data);
        int a;
        a = int'(addr);
        if (a >= im_base && a < im_base + im_depth) begin
            model_imem[a - im_base] = data;
        end else if (a >= od_base && a < od_base + od_depth) begin
            model_od[a - od_base] = data[`IFD_CTRL_WIDTH-1:0];
        end
    endfunction

    function automatic decoded_t predict(input im_addr_t addr, input thread_t thr);
        decoded_t   p;
        word_t      w;
        opcode_t    op;
        d_operand_t d;
        w = model_imem[addr];
        op = w[op_lsb +: `IFD_OPCODE_WIDTH];
        d = w[d_lsb +: `IFD_D_WIDTH];
        p.alu_control = model_od[int'(thr) * (1 << `IFD_OPCODE_WIDTH) + int'(op)];
        p.da = d;
        p.db = d + `IFD_DB_BASE;
        p.a = w[a_lsb +: `IFD_A_WIDTH];
        p.b = w[0 +: `IFD_B_WIDTH];
        return p;
    endfunction

    // ------------------------------------------------------------------------
    // Drivers

    task automatic next_cycle();
        @(posedge clock);
        #1;
    endtask

    task automatic host_write(input addr_t addr, input word_t data);
        int   waited;
        logic taken;
        next_cycle();
        aw_valid = 1'b1;
        w_valid = 1'b1;
        aw_addr = addr;
        w_data = data;
        taken = 1'b0;
        for (waited = 0; waited < wait_limit && !taken; waited++) begin
            @(negedge clock);
            taken = aw_ready;
            next_cycle();
        end
        aw_valid = 1'b0;
        w_valid = 1'b0;
        if (!taken) begin
            $display("Host write to %h was never accepted on AW/W", addr);
            driver_errors++;
            return;
        end
        taken = 1'b0;
        for (waited = 0; waited < wait_limit && !taken; waited++) begin
            @(negedge clock);
            taken = b_valid;
            next_cycle();
        end
        if (!taken) begin
            $display("Host write to %h got no B response", addr);
            driver_errors++;
        end else begin
            model_write(addr, data);
        end
    endtask

    task automatic core_write(input logic valid, input logic ior, input logic cancel,
                              input addr_t addr, input word_t data);
        next_cycle();
        core_req.valid = valid;
        core_req.addr = addr;
        core_req.data = data;
        ior_previous = ior;
        cancel_previous = cancel;
        if (valid && ior && !cancel) begin
            model_write(addr, data);
        end
    endtask

    task automatic core_release();
        next_cycle();
        core_req = '0;
        ior_previous = 1'b0;
        cancel_previous = 1'b0;
    endtask

    // Back-to-back fetches over the queue, then drain the pipeline
    task automatic fetch_list();
        foreach (written_q[k]) begin
            next_cycle();
            im_read_addr = written_q[k];
            exp_out = predict(written_q[k], thread_t'(release_edges % `IFD_THREAD_COUNT));
            exp_valid = 1'b1;
        end
        next_cycle();
        exp_valid = 1'b0;
        repeat (2) next_cycle();
    endtask

    task automatic close_run();
        $display("Closing counts: %0d checker errors, %0d driver errors, %0d fetches compared",
                 checker_errors, driver_errors, compare_count);
        if (checker_errors == 0 && driver_errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    initial begin
        #(watchdog_ns);
        $display("Watchdog expired after %0d ns before the sequence finished", watchdog_ns);
        driver_errors++;
        close_run();
    end

    // ------------------------------------------------------------------------
    // Sequence

    initial begin
        int    i;
        int    idx;
        int    op;
        addr_t addr;
        word_t rnd_word;
        rst = 1'b1;
        aw_valid = 1'b0;
        aw_addr = '0;
        w_valid = 1'b0;
        w_data = '0;
        b_ready = 1'b0;
        core_req = '0;
        ior_previous = 1'b0;
        cancel_previous = 1'b0;
        im_read_addr = '0;
        exp_valid = 1'b0;
        exp_out = '0;
        test_id = t_reset;
        check_end = 1'b0;
        driver_errors = 0;
        repeat (3) @(posedge clock);
        #1;
        rst = 1'b0;
        b_ready = 1'b1;
        repeat (4) next_cycle();

        // Host loads every decoder entry and random instruction words
        test_id = t_host_loading;
        for (i = 0; i < od_depth; i++) begin
            host_write(addr_t'(od_base + i), rand_word());
        end
        for (i = 0; i < load_writes; i++) begin
            idx = rand_below(im_depth);
            host_write(addr_t'(im_base + idx), rand_word());
            written_q.push_back(im_addr_t'(idx));
        end
        fetch_list();

        // Only qualified core writes may change anything
        test_id = t_annul_cancel;
        for (i = 0; i < core_phase_writes; i++) begin
            if (rand_below(2) == 1) begin
                addr = addr_t'(im_base + written_q[rand_below(written_q.size())]);
            end else begin
                addr = addr_t'(od_base + rand_below(od_depth));
            end
            core_write(rand_below(4) != 0, rand_below(2) == 1, rand_below(2) == 1,
                       addr, rand_word());
        end
        core_release();
        fetch_list();

        test_id = t_out_of_range;
        for (i = 0; i < range_writes; i++) begin
            if (rand_below(2) == 1) begin
                addr = addr_t'(rand_below(im_base));
            end else begin
                addr = addr_t'(od_base + od_depth + rand_below(4096 - od_base - od_depth));
            end
            host_write(addr, rand_word());
        end
        fetch_list();

        // Core burst to the low quarter, host writes to the third quarter
        test_id = t_arbitration;
        fork
            begin : core_burst
                int n;
                int cidx;
                for (n = 0; n < burst_len; n++) begin
                    cidx = rand_below(im_depth / 4);
                    if (n < burst_len / 2) begin
                        core_write(1'b1, 1'b1, 1'b0, addr_t'(im_base + cidx), rand_word());
                    end else begin
                        core_write(1'b1, rand_below(2) == 1, rand_below(2) == 1,
                                   addr_t'(im_base + cidx), rand_word());
                    end
                    written_q.push_back(im_addr_t'(cidx));
                end
                core_release();
            end
            begin : host_during_burst
                int n;
                int hidx;
                for (n = 0; n < burst_host_writes; n++) begin
                    hidx = im_depth / 2 + rand_below(im_depth / 4);
                    host_write(addr_t'(im_base + hidx), rand_word());
                    written_q.push_back(im_addr_t'(hidx));
                end
            end
        join
        fetch_list();

        // One opcode, a distinct control word in each thread
        test_id = t_per_thread;
        op = rand_below(1 << `IFD_OPCODE_WIDTH);
        for (i = 0; i < `IFD_THREAD_COUNT; i++) begin
            rnd_word = rand_word();
            host_write(addr_t'(od_base + i * (1 << `IFD_OPCODE_WIDTH) + op),
                       {rnd_word[`IFD_WORD_WIDTH-1:`IFD_THREAD_WIDTH], thread_t'(i)});
        end
        written_q.delete();
        for (i = 0; i < thread_words; i++) begin
            idx = im_depth - im_depth / 4 + i;
            rnd_word = rand_word();
            host_write(addr_t'(im_base + idx), {opcode_t'(op), rnd_word[op_lsb-1:0]});
            written_q.push_back(im_addr_t'(idx));
        end
        fetch_list();
        fetch_list();

        next_cycle();
        check_end = 1'b1;
        next_cycle();
        check_end = 1'b0;
        repeat (2) next_cycle();
        if (compare_count == 0) begin
            $display("No fetch result was compared");
            driver_errors++;
        end
        close_run();
    end

endmodule

/* filelist.f */
+incdir+.
ifd_pkg.sv
host_write_port.sv
write_arbiter.sv
write_space_decoder.sv
instruction_fetch_decode.sv
ifd_mapped_top.sv
tb_ifd_checker.sv
tb_ifd.sv

/* Bender.yml */
package:
  name: ifd_mapped

export_include_dirs:
  - .

sources:
  - files:
      - ifd_pkg.sv
      - host_write_port.sv
      - write_arbiter.sv
      - write_space_decoder.sv
      - instruction_fetch_decode.sv
      - ifd_mapped_top.sv
  - target: test
    files:
      - tb_ifd_checker.sv
      - tb_ifd.sv
